//--- sim.f
hw/cpu_isa_pkg.sv
hw/cpu_ctrl_pkg.sv
hw/stack_ctl_if.sv
hw/pc_upd_if.sv
hw/branch_cond.sv
hw/stack_seq.sv
hw/pc_unit.sv
hw/ucode_seq.sv
hw/cpu_ctrl.sv
tb/cpu_ctrl_assert.sv
tb/tb_cpu_ctrl.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the control section testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f sim.f --top-module tb_cpu_ctrl -o tb_cpu_ctrl
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/tb_cpu_ctrl 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qxF '>>> PASS'; then
    exit 0
fi
exit 1

//--- tb/ctrl_tests.txt
# op operand cc pul_data expected_pc slots   (hex, slots decimal)
# pc carries over from one line to the next, starting at 0100
12 0000 00 00 0101 0
20 0010 00 00 0113 0
80 0100 00 00 0216 0
21 0040 00 00 0218 0
81 1234 00 00 021B 0
22 00F0 00 00 020D 0
82 0050 01 00 0210 0
23 007F 04 00 0291 0
83 0020 00 00 0294 0
24 0080 30 00 0216 0
84 0300 01 00 0219 0
25 0005 01 00 0220 0
85 0010 00 00 0223 0
26 00FE F0 00 0223 0
86 0000 04 00 0226 0
27 0020 04 00 0248 0
87 0008 00 00 024B 0
28 0030 02 00 024D 0
88 0100 00 00 0350 0
29 0010 00 00 0352 0
89 FF00 02 00 0255 0
2A 0011 08 00 0257 0
8A 0021 00 00 027B 0
2B 0022 00 00 027D 0
8B FFF0 08 00 0270 0
2C 0033 08 00 0272 0
8C 0400 0A 00 0675 0
2D 0044 0A 00 0677 0
8D FC00 02 00 027A 0
2E 0055 08 00 027C 0
8E 0006 00 00 0285 0
2F 0066 0A 00 0287 0
8F 1000 04 00 128A 0
7E 4000 00 00 4000 0
3A 0000 00 00 4001 0
34 0081 00 00 4003 3
34 00FF 00 00 4005 9
34 0000 00 00 4007 0
34 0016 00 00 4009 3
35 0006 00 55 400B 2
35 0083 00 A5 A5A5 4
35 0080 00 3C 3C3C 2
35 00FF 00 21 2121 9
4F 0000 00 00 2122 0

//--- tb/tb_cpu_ctrl.sv
// ########################################
// testbench for the control section
// reads tb/ctrl_tests.txt, run from project root
// each test strobes in the cycle after done
// expected pc in the file carries over
// ########################################

module tb_cpu_ctrl import cpu_isa_pkg::*; ();

    logic    clk = 1'b0;
    logic    rst;
    logic    op_valid;
    opcode_t op;
    word_t   operand;
    byte_t   cc;
    byte_t   pul_data;
    logic    busy;
    logic    done;
    word_t   pc;
    byte_t   psh_sel;
    logic    pul_en;
    logic    stack_we;
    logic    hihalf;

    opcode_t q_op[$];
    word_t   q_operand[$];
    byte_t   q_cc[$];
    byte_t   q_pul[$];
    word_t   q_pc[$];
    int      q_slots[$];

    int     n_tests = 0;
    int     errors = 0;
    integer seed;

    cpu_ctrl DUT (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .op_valid ( op_valid ),
        .op       ( op       ),
        .operand  ( operand  ),
        .cc       ( cc       ),
        .pul_data ( pul_data ),
        .busy     ( busy     ),
        .done     ( done     ),
        .pc       ( pc       ),
        .psh_sel  ( psh_sel  ),
        .pul_en   ( pul_en   ),
        .stack_we ( stack_we ),
        .hihalf   ( hihalf   )
    );

    always #2 clk = ~clk;

    task automatic flag_error(input string msg);
        errors++;
        $display("CHECK FAILED t=%0t %s", $time, msg);
    endtask

    function automatic byte_t random_byte();
        int r;
        r = $random(seed);
        return r[7:0];
    endfunction

    // cc only matters for the branches
    function automatic logic is_inherent(input opcode_t o);
        return (o[7:4] != OP_BR_BASE[7:4]) && (o[7:4] != OP_LBR_BASE[7:4]) &&
            (o != OP_JMP) && (o != OP_PSH) && (o != OP_PUL);
    endfunction

    function automatic int slot_index(input byte_t sel);
        int b;
        b = -1;
        for (int i = 0; i < 8; i++) begin
            if (sel == (8'h01 << i)) b = i;
        end
        return b;
    endfunction

    task automatic load_tests();
        int      fd;
        string   line;
        opcode_t f_op;
        word_t   f_operand;
        byte_t   f_cc;
        byte_t   f_pul;
        word_t   f_pc;
        int      f_slots;
        fd = $fopen("tb/ctrl_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/ctrl_tests.txt");
        end else begin
            // lines starting with # fail the scan and are skipped
            while ($fgets(line, fd) != 0) begin
                if ($sscanf(line, "%h %h %h %h %h %d", f_op, f_operand, f_cc, f_pul,
                        f_pc, f_slots) == 6) begin
                    q_op.push_back(f_op);
                    q_operand.push_back(f_operand);
                    q_cc.push_back(f_cc);
                    q_pul.push_back(f_pul);
                    q_pc.push_back(f_pc);
                    q_slots.push_back(f_slots);
                end
            end
            $fclose(fd);
        end
        n_tests = q_op.size();
    endtask

    task automatic run_test(input int idx);
        logic push;
        logic pull;
        logic order_ok;
        logic half_exp;
        int   cycles;
        int   slots;
        int   bit_idx;
        int   prev_bit;
        int   pc_cycles;
        push      = (q_op[idx] == OP_PSH);
        pull      = (q_op[idx] == OP_PUL);
        cycles    = 0;
        slots     = 0;
        prev_bit  = -1;
        pc_cycles = 0;
        @(negedge clk);
        op_valid = 1'b1;
        op       = q_op[idx];
        operand  = q_operand[idx];
        pul_data = q_pul[idx];
        cc       = is_inherent(q_op[idx]) ? random_byte() : q_cc[idx];
        do begin
            @(negedge clk);
            op_valid = 1'b0;
            cc       = random_byte();
            cycles++;
            assert (busy) else
                flag_error($sformatf("test %0d busy low %0d cycles after the strobe",
                    idx, cycles));
            if (psh_sel != 8'h00) begin
                bit_idx = slot_index(psh_sel);
                slots++;
                // only the PC bit may show up twice in a row
                order_ok = (prev_bit < 0) ||
                    (push ? (bit_idx < prev_bit) : (bit_idx > prev_bit)) ||
                    (bit_idx == 7 && prev_bit == 7 && pc_cycles == 1);
                assert (order_ok && (psh_sel & operand[7:0]) != 8'h00) else
                    flag_error($sformatf("test %0d slot %0d out of order or not in mask %02h",
                        idx, bit_idx, operand[7:0]));
                assert (push ? (stack_we && !pul_en) : (pul_en && !stack_we)) else
                    flag_error($sformatf("test %0d stack_we %0b pul_en %0b on slot %0d",
                        idx, stack_we, pul_en, bit_idx));
                half_exp = (bit_idx == 7) && (pull ? (pc_cycles == 0) : (pc_cycles == 1));
                assert (hihalf == half_exp) else
                    flag_error($sformatf("test %0d hihalf %0b, expected %0b",
                        idx, hihalf, half_exp));
                if (bit_idx == 7) pc_cycles++;
                prev_bit = bit_idx;
            end
        end while (!done);
        assert (pc == q_pc[idx]) else
            flag_error($sformatf("test %0d op %02h pc %04h, expected %04h",
                idx, q_op[idx], pc, q_pc[idx]));
        assert (slots == q_slots[idx]) else
            flag_error($sformatf("test %0d op %02h slots %0d, expected %0d",
                idx, q_op[idx], slots, q_slots[idx]));
        // two cycles of decode and update plus one per slot
        assert (cycles == 2 + q_slots[idx]) else
            flag_error($sformatf("test %0d done after %0d cycles, expected %0d",
                idx, cycles, 2 + q_slots[idx]));
    endtask

    initial begin
        wait (n_tests > 0);
        repeat (n_tests * 40) @(posedge clk);
        $display("run timed out after %0d cycles, errors %0d", n_tests * 40, errors);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        rst      = 1'b1;
        op_valid = 1'b0;
        op       = '0;
        operand  = '0;
        cc       = '0;
        pul_data = '0;
        seed     = 32'h2e25;
        load_tests();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        assert (pc == 16'h0100 && !busy && !done) else
            flag_error($sformatf("after reset pc %04h busy %0b done %0b", pc, busy, done));
        if (n_tests == 0) begin
            $display("no tests were run, the test file is missing or empty");
            errors++;
        end
        for (int i = 0; i < n_tests; i++) begin
            run_test(i);
        end
        $display("tests %0d, errors %0d", n_tests, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- tb/cpu_ctrl_assert.sv
// ########################################
// bound checks on the control section
// handshake and stack slot outputs only
// disabled while rst is high
// ########################################

module cpu_ctrl_assert import cpu_isa_pkg::*; (
    input logic  clk,
    input logic  rst,
    input logic  op_valid,
    input logic  busy,
    input logic  done,
    input byte_t psh_sel,
    input logic  stack_we,
    input logic  pul_en
);

    // at most one slot per cycle
    slot_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(psh_sel))
        else $error("psh_sel selects more than one slot");

    push_pull_excl: assert property (@(posedge clk) disable iff (rst) !(stack_we && pul_en))
        else $error("stack_we and pul_en are high together");

    // no back-pressure, producer must wait for idle
    strobe_idle: assert property (@(posedge clk) disable iff (rst) op_valid |-> !busy)
        else $error("op_valid strobed while busy");

    done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done held longer than one cycle");

endmodule

bind cpu_ctrl cpu_ctrl_assert u_assert (
    .clk      ( clk      ),
    .rst      ( rst      ),
    .op_valid ( op_valid ),
    .busy     ( busy     ),
    .done     ( done     ),
    .psh_sel  ( psh_sel  ),
    .stack_we ( stack_we ),
    .pul_en   ( pul_en   )
);

//--- hw/cpu_ctrl.sv
// ########################################
// control section top
// op_valid must stay low while busy is high
// pul_data feeds the pc byte loads directly
// ########################################

module cpu_ctrl import cpu_isa_pkg::*; #(
    parameter word_t RESET_PC = 16'h0100
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    op_valid,
    input  opcode_t op,
    input  word_t   operand,
    input  byte_t   cc,
    input  byte_t   pul_data,
    output logic    busy,
    output logic    done,
    output word_t   pc,
    output byte_t   psh_sel,
    output logic    pul_en,
    output logic    stack_we,
    output logic    hihalf
);

    logic taken;

    stack_ctl_if stk_if ();
    pc_upd_if    upd_if ();

    // condition evaluated on the live opcode, latched at acceptance
    branch_cond u_branch (
        .op    ( op    ),
        .cc    ( cc    ),
        .taken ( taken )
    );

    ucode_seq u_seq (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .op_valid ( op_valid ),
        .op       ( op       ),
        .operand  ( operand  ),
        .taken    ( taken    ),
        .stk      ( stk_if   ),
        .upd      ( upd_if   ),
        .busy     ( busy     ),
        .done     ( done     )
    );

    stack_seq u_stack (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .ctl      ( stk_if   ),
        .psh_sel  ( psh_sel  ),
        .stack_we ( stack_we ),
        .pul_en   ( pul_en   )
    );

    pc_unit #(
        .RESET_PC ( RESET_PC )
    ) u_pc (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .pul_data ( pul_data ),
        .upd      ( upd_if   ),
        .pc       ( pc       )
    );

    assign hihalf = stk_if.hihalf;

endmodule

//--- hw/ucode_seq.sv
// ########################################
// instruction sequencer
// accepts one opcode while idle, no back-pressure
// pc updated one cycle after acceptance
// done is a single cycle pulse
// ########################################

module ucode_seq import cpu_isa_pkg::*, cpu_ctrl_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    op_valid,
    input  opcode_t op,
    input  word_t   operand,
    input  logic    taken,
    stack_ctl_if.seq stk,
    pc_upd_if.seq   upd,
    output logic    busy,
    output logic    done
);

    seq_state_t state;
    seq_state_t state_nxt;
    op_class_t  cls_r;
    word_t      operand_r;
    logic       taken_r;
    logic       stack_op;
    logic       pc_pull;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            cls_r <= CLS_INH;
        end else begin
            state <= state_nxt;
            if (state == S_IDLE && op_valid) cls_r <= op_class(op);
        end
    end

    // branch condition sampled together with the opcode
    always_ff @(posedge clk) begin
        if (state == S_IDLE && op_valid) begin
            operand_r <= operand;
            taken_r   <= taken;
        end
    end

    assign stack_op = (cls_r == CLS_PSH) || (cls_r == CLS_PUL);
    assign pc_pull  = (cls_r == CLS_PUL) && stk.sbusy && (stk.cur_bit == slot_t'(MASK_PC));

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE:  if (op_valid) state_nxt = S_EXEC;
            // empty mask finishes like any other instruction
            S_EXEC:  state_nxt = (stack_op && |operand_r[7:0]) ? S_STACK : S_DONE;
            S_STACK: if (stk.last || !stk.sbusy) state_nxt = S_DONE;
            default: state_nxt = S_IDLE;
        endcase
    end

    always_comb begin
        upd.kind   = PC_HOLD;
        upd.len    = 2'd1;
        upd.offset = '0;
        stk.start  = 1'b0;
        stk.pull   = (cls_r == CLS_PUL);
        stk.mask   = operand_r[7:0];
        if (state == S_EXEC) begin
            case (cls_r)
                CLS_BR8: begin
                    upd.len    = 2'd2;
                    upd.kind   = taken_r ? PC_REL8 : PC_ADV;
                    upd.offset = {{8{operand_r[7]}}, operand_r[7:0]};
                end
                CLS_BR16: begin
                    upd.len    = 2'd3;
                    upd.kind   = taken_r ? PC_REL16 : PC_ADV;
                    upd.offset = operand_r;
                end
                CLS_JMP: begin
                    upd.len    = 2'd3;
                    upd.kind   = PC_ABS;
                    upd.offset = operand_r;
                end
                CLS_PSH, CLS_PUL: begin
                    upd.len   = 2'd2;
                    upd.kind  = PC_ADV;
                    stk.start = |operand_r[7:0];
                end
                default: begin
                    upd.kind = PC_ADV;
                end
            endcase
        end else if (state == S_STACK && pc_pull) begin
            // pulled PC overwrites the advanced value
            upd.kind = stk.hihalf ? PC_LDHI : PC_LDLO;
        end
    end

    assign busy = (state != S_IDLE);
    assign done = (state == S_DONE);

endmodule

//--- hw/pc_unit.sv
// ########################################
// program counter register
// one update kind per cycle
// byte loads replace one half only
// ########################################

module pc_unit import cpu_isa_pkg::*, cpu_ctrl_pkg::*; #(
    parameter word_t RESET_PC = 16'h0100
) (
    input  logic  clk,
    input  logic  rst,
    input  byte_t pul_data,
    pc_upd_if.pc  upd,
    output word_t pc
);

    word_t pc_seq;
    word_t pc_jmp;

    // next sequential address and branch target
    assign pc_seq = pc + word_t'(upd.len);
    assign pc_jmp = pc_seq + upd.offset;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else begin
            case (upd.kind)
                PC_ADV: begin
                    pc <= pc_seq;
                end
                PC_REL8, PC_REL16: begin
                    pc <= pc_jmp;
                end
                PC_ABS: begin
                    pc <= upd.offset;
                end
                PC_LDHI: begin
                    pc[15:8] <= pul_data;
                end
                PC_LDLO: begin
                    pc[7:0] <= pul_data;
                end
                default: begin
                    pc <= pc;
                end
            endcase
        end
    end

endmodule

//--- hw/stack_seq.sv
// ########################################
// push/pull slot sequencer
// push serves mask bits 7 down to 0
// pull serves mask bits 0 up to 7
// PC slot takes two cycles, hihalf marks
// the high byte
// ########################################

module stack_seq import cpu_isa_pkg::*, cpu_ctrl_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    stack_ctl_if.stack ctl,
    output byte_t psh_sel,
    output logic  stack_we,
    output logic  pul_en
);

    byte_t mask_r;
    logic  pull_r;
    logic  second;
    logic  active;
    logic  pc_slot;
    slot_t cur;
    byte_t rest;

    // highest set bit for push, lowest for pull
    always_comb begin
        cur = '0;
        if (pull_r) begin
            for (int i = 7; i >= 0; i--) begin
                if (mask_r[i]) cur = slot_t'(i);
            end
        end else begin
            for (int i = 0; i < 8; i++) begin
                if (mask_r[i]) cur = slot_t'(i);
            end
        end
    end

    assign active  = |mask_r;
    assign pc_slot = active && (cur == slot_t'(MASK_PC));
    assign rest    = mask_r & ~(byte_t'(1) << cur);

    always_ff @(posedge clk) begin
        if (rst) begin
            mask_r <= '0;
            pull_r <= 1'b0;
            second <= 1'b0;
        end else if (ctl.start) begin
            mask_r <= ctl.mask;
            pull_r <= ctl.pull;
            second <= 1'b0;
        end else if (active) begin
            if (pc_slot && !second) begin
                second <= 1'b1;
            end else begin
                mask_r <= rest;
                second <= 1'b0;
            end
        end
    end

    // push does low byte first, pull high byte first
    assign ctl.hihalf  = pc_slot & (second ^ pull_r);
    assign ctl.sbusy   = active;
    assign ctl.cur_bit = cur;
    assign ctl.last    = active && (rest == '0) && (!pc_slot || second);

    assign psh_sel  = active ? (byte_t'(1) << cur) : '0;
    assign stack_we = active & ~pull_r;
    assign pul_en   = active & pull_r;

endmodule

//--- hw/branch_cond.sv
// ########################################
// 6809 branch condition decode
// uses only C, V, Z and N
// purely combinational
// ########################################

module branch_cond import cpu_isa_pkg::*; (
    input  opcode_t op,
    input  byte_t   cc,
    output logic    taken
);

    logic n_xor_v;
    logic cond;

    assign n_xor_v = cc[CC_N] ^ cc[CC_V];

    // odd codes use the true form, even codes its complement
    always_comb begin
        case (op[3:1])
            3'd0:    cond = 1'b0;                      // BRN / BRA
            3'd1:    cond = cc[CC_C] | cc[CC_Z];       // BLS / BHI
            3'd2:    cond = cc[CC_C];                  // BCS / BCC
            3'd3:    cond = cc[CC_Z];                  // BEQ / BNE
            3'd4:    cond = cc[CC_V];                  // BVS / BVC
            3'd5:    cond = cc[CC_N];                  // BMI / BPL
            3'd6:    cond = n_xor_v;                   // BLT / BGE
            default: cond = cc[CC_Z] | n_xor_v;        // BLE / BGT
        endcase
    end

    assign taken = op[0] ? cond : ~cond;

endmodule

//--- hw/pc_upd_if.sv
// ########################################
// sequencer to program counter link
// offset is already sign-extended
// len counts instruction bytes
// ########################################

interface pc_upd_if import cpu_isa_pkg::*, cpu_ctrl_pkg::*; ();

    pc_kind_t kind;
    len_t     len;
    word_t    offset;

    // offset doubles as absolute target for PC_ABS
    modport seq (
        output kind, len, offset
    );

    modport pc (
        input kind, len, offset
    );

endinterface

//--- hw/stack_ctl_if.sv
// ########################################
// sequencer to stack sequencer link
// start is a single cycle strobe
// mask and pull only sampled with start
// ########################################

interface stack_ctl_if import cpu_isa_pkg::*, cpu_ctrl_pkg::*; ();

    logic  start;
    logic  pull;
    byte_t mask;

    logic  sbusy;
    slot_t cur_bit;
    logic  hihalf;
    logic  last;

    modport seq (
        output start, pull, mask,
        input  sbusy, cur_bit, hihalf, last
    );

    modport stack (
        input  start, pull, mask,
        output sbusy, cur_bit, hihalf, last
    );

endinterface

//--- hw/cpu_ctrl_pkg.sv
// ########################################
// internal types of the control section
// slot index follows the mask bit number
// ########################################

package cpu_ctrl_pkg;

    typedef enum logic [1:0] {
        S_IDLE,
        S_EXEC,
        S_STACK,
        S_DONE
    } seq_state_t;

    // one update kind applies per cycle
    typedef enum logic [2:0] {
        PC_HOLD,
        PC_ADV,
        PC_REL8,
        PC_REL16,
        PC_ABS,
        PC_LDLO,
        PC_LDHI
    } pc_kind_t;

    // push/pull slot, equal to the mask bit being served
    typedef logic [2:0] slot_t;

    // instruction length in bytes, 1 to 3
    typedef logic [1:0] len_t;

endpackage

//--- hw/cpu_isa_pkg.sv
// ########################################
// instruction set view of the control section
// only branches, jump, push and pull have operands
// every other opcode is a 1-byte inherent
// ########################################

package cpu_isa_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] word_t;
    typedef logic [7:0]  opcode_t;

    // short branches 20..2F, long branches 80..8F
    localparam opcode_t OP_BR_BASE  = 8'h20;
    localparam opcode_t OP_LBR_BASE = 8'h80;
    localparam opcode_t OP_JMP      = 8'h7E;
    localparam opcode_t OP_PSH      = 8'h34;
    localparam opcode_t OP_PUL      = 8'h35;

    typedef enum logic [2:0] {
        CLS_INH,
        CLS_BR8,
        CLS_BR16,
        CLS_JMP,
        CLS_PSH,
        CLS_PUL
    } op_class_t;

    // condition code bits
    localparam int CC_C = 0;
    localparam int CC_V = 1;
    localparam int CC_Z = 2;
    localparam int CC_N = 3;
    localparam int CC_I = 4;
    localparam int CC_H = 5;
    localparam int CC_F = 6;
    localparam int CC_E = 7;

    // post-byte mask, bit 7 is PC (two bytes), the rest one byte each
    localparam int MASK_PC = 7;

    function automatic op_class_t op_class(opcode_t op);
        op_class_t c;
        if (op[7:4] == OP_BR_BASE[7:4]) c = CLS_BR8;
        else if (op[7:4] == OP_LBR_BASE[7:4]) c = CLS_BR16;
        else if (op == OP_JMP) c = CLS_JMP;
        else if (op == OP_PSH) c = CLS_PSH;
        else if (op == OP_PUL) c = CLS_PUL;
        else c = CLS_INH;
        return c;
    endfunction

endpackage
